// ==== flist.f ====
+incdir+.
rowsum_pkg.sv
r1_loader.sv
r2_controller.sv
r2_datapath.sv
frame_mem_arbiter.sv
rowsum_top.sv
rowsum_assertions.sv
rowsum_checker.sv
tb_rowsum.sv

// ==== frame_mem_arbiter.sv ====
`include "rowsum_settings.svh"

module frame_mem_arbiter
    import rowsum_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_ld_req,
    input  logic [`ROWSUM_ADDR_W-1:0] i_ld_addr,
    input  logic [`ROWSUM_WORD_W-1:0] i_ld_wdata,
    input  logic                      i_flt_req,
    input  logic [`ROWSUM_ADDR_W-1:0] i_flt_addr,
    input  logic                      i_flt_we,
    input  logic [`ROWSUM_WORD_W-1:0] i_flt_wdata,
    input  logic                      i_host_req,
    input  logic [`ROWSUM_ADDR_W-1:0] i_host_addr,
    output logic                      o_ld_gnt,
    output logic                      o_flt_gnt,
    output logic [`ROWSUM_WORD_W-1:0] o_host_rdata,
    output logic                      o_host_rvalid,
    output logic [`ROWSUM_WORD_W-1:0] o_flt_rdata,
    output logic                      o_flt_rvalid
);

    localparam int DEPTH = 1 << `ROWSUM_ADDR_W;

    req_id_t                   gnt_id;
    req_id_t                   rd_id;
    logic [`ROWSUM_ADDR_W-1:0] mem_addr;
    logic                      mem_we;
    logic [`ROWSUM_WORD_W-1:0] mem_wdata;
    logic [`ROWSUM_WORD_W-1:0] rd_data;
    logic [`ROWSUM_WORD_W-1:0] mem [DEPTH];

    // fixed priority: loader, then filter, then host.
    always_comb begin
        if (i_ld_req) gnt_id = REQ_LOADER;
        else if (i_flt_req) gnt_id = REQ_FILTER;
        else if (i_host_req) gnt_id = REQ_HOST;
        else gnt_id = REQ_NONE;
    end

    assign o_ld_gnt  = gnt_id == REQ_LOADER;
    assign o_flt_gnt = gnt_id == REQ_FILTER;

    always_comb begin
        mem_addr  = i_host_addr;
        mem_we    = 1'b0;
        mem_wdata = i_ld_wdata;
        case (gnt_id)
            REQ_LOADER: begin
                mem_addr = i_ld_addr;
                mem_we   = 1'b1;
            end
            REQ_FILTER: begin
                mem_addr  = i_flt_addr;
                mem_we    = i_flt_we;
                mem_wdata = i_flt_wdata;
            end
            default: mem_addr = i_host_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_we) mem[mem_addr] <= mem_wdata;
        rd_data <= mem[mem_addr];
    end

    // remember who issued a read so the data goes back with the right valid.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_id <= REQ_NONE;
        end else if (gnt_id == REQ_HOST || (gnt_id == REQ_FILTER && !i_flt_we)) begin
            rd_id <= gnt_id;
        end else begin
            rd_id <= REQ_NONE;
        end
    end

    assign o_host_rdata  = rd_data;
    assign o_flt_rdata   = rd_data;
    assign o_host_rvalid = rd_id == REQ_HOST;
    assign o_flt_rvalid  = rd_id == REQ_FILTER;

endmodule

// ==== r1_loader.sv ====
`include "rowsum_settings.svh"

module r1_loader
    import rowsum_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_pix_valid,
    input  logic [`ROWSUM_PIX_W-1:0]  i_pix_data,
    input  logic                      i_gnt,
    output logic                      o_req,
    output logic [`ROWSUM_ADDR_W-1:0] o_addr,
    output mem_word_t                 o_wdata,
    output logic                      o_busy,
    output logic                      o_done
);

    localparam int ADDR_W = `ROWSUM_ADDR_W;
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`ROWSUM_OUT_BASE - 1);

    logic                     pend_valid;
    logic [`ROWSUM_PIX_W-1:0] pend_data;
    logic [ADDR_W-1:0]        wr_addr;
    logic                     wr_fire;

    assign o_req   = i_pix_valid | pend_valid;
    assign o_addr  = wr_addr;
    assign o_busy  = pend_valid;
    assign wr_fire = o_req & i_gnt;

    // a pending pixel always goes out before a new one.
    always_comb begin
        o_wdata.px.pad = '0;
        o_wdata.px.pix = pend_valid ? pend_data : i_pix_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_addr    <= '0;
            pend_valid <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done <= wr_fire && (wr_addr == LAST_ADDR);
            if (wr_fire) begin
                pend_valid <= 1'b0;
                wr_addr    <= (wr_addr == LAST_ADDR) ? '0 : wr_addr + 1'b1;
            end else if (i_pix_valid) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_pix_valid && !i_gnt && !pend_valid) begin
            pend_data <= i_pix_data;
        end
    end

endmodule

// ==== r2_controller.sv ====
`include "rowsum_settings.svh"

module r2_controller (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_done,
    input  logic       i_gnt,
    input  logic       i_start_gt_1,
    input  logic [9:0] i_counter,
    input  logic       i_row_eq_max,
    output logic       o_start_en,
    output logic       o_ld_en,
    output logic       o_count_en,
    output logic       o_sum_en,
    output logic       o_cum_en,
    output logic       o_done,
    output logic       o_progress_done
);

    localparam logic [2:0] IDLE       = 3'd0;
    localparam logic [2:0] START      = 3'd1;
    localparam logic [2:0] START_ROW  = 3'd2;
    localparam logic [2:0] SUM_EN     = 3'd3;
    localparam logic [2:0] CUM_EN     = 3'd4;
    localparam logic [2:0] FINISH_ALL = 3'd5;
    localparam logic [2:0] DONE       = 3'd6;

    // the first window is complete once its last pixel has been read.
    localparam logic [9:0] WIN_LAST = 10'(`ROWSUM_WIN - 1);
    // the row closes with the write of its last sum, right after its last pixel is read.
    localparam logic [9:0] ROW_END  = 10'(`ROWSUM_COLS);

    logic [2:0] state;
    logic [2:0] next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (i_gnt) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_done) next_state = START;
            end
            START: begin
                if (i_start_gt_1) next_state = START_ROW;
            end
            START_ROW: begin
                next_state = i_row_eq_max ? FINISH_ALL : SUM_EN;
            end
            SUM_EN: begin
                if (i_counter > WIN_LAST) next_state = CUM_EN;
            end
            CUM_EN: begin
                if (i_counter == ROW_END) next_state = START_ROW;
            end
            FINISH_ALL: next_state = DONE;
            DONE:       next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    always_comb begin
        o_start_en      = 1'b0;
        o_ld_en         = 1'b0;
        o_count_en      = 1'b0;
        o_sum_en        = 1'b0;
        o_cum_en        = 1'b0;
        o_done          = 1'b0;
        o_progress_done = 1'b0;
        case (state)
            START: o_start_en = 1'b1;
            START_ROW: o_ld_en = 1'b1;
            SUM_EN: begin
                o_count_en = 1'b1;
                o_sum_en   = 1'b1;
            end
            CUM_EN: begin
                o_count_en = 1'b1;
                o_cum_en   = 1'b1;
                o_done     = 1'b1;
            end
            FINISH_ALL: o_progress_done = 1'b1;
            default: o_progress_done = 1'b0;
        endcase
    end

endmodule

// ==== r2_datapath.sv ====
`include "rowsum_settings.svh"

module r2_datapath
    import rowsum_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_start_en,
    input  logic                      i_ld_en,
    input  logic                      i_count_en,
    input  logic                      i_sum_en,
    input  logic                      i_cum_en,
    input  logic                      i_done,
    input  logic                      i_gnt,
    output logic                      o_start_gt_1,
    output logic [9:0]                o_counter,
    output logic                      o_row_eq_max,
    output logic                      o_req,
    output logic [`ROWSUM_ADDR_W-1:0] o_addr,
    output logic                      o_we,
    output mem_word_t                 o_wdata,
    input  mem_word_t                 i_rdata,
    input  logic                      i_rvalid
);

    localparam int ADDR_W = `ROWSUM_ADDR_W;
    localparam int WORD_W = `ROWSUM_WORD_W;
    localparam int PIX_W  = `ROWSUM_PIX_W;
    localparam int WIN    = `ROWSUM_WIN;
    localparam logic [9:0] COLS = 10'(`ROWSUM_COLS);
    localparam logic [9:0] ROWS = 10'(`ROWSUM_ROWS);
    localparam logic [9:0] WIN_CNT = 10'(WIN);
    localparam logic [ADDR_W-1:0] OUT_BASE = ADDR_W'(`ROWSUM_OUT_BASE);

    logic [1:0]        start_cnt;
    logic [9:0]        col;
    logic [9:0]        row;
    logic [ADDR_W-1:0] row_base;
    logic [ADDR_W-1:0] out_ptr;
    logic              cum_rd;
    logic              sum_rd;
    logic              access;
    logic [PIX_W-1:0]  win [WIN];
    logic [WORD_W-1:0] acc;
    logic [WORD_W-1:0] acc_upd;

    // while the window fills, one read per column; afterwards writes and reads alternate.
    assign sum_rd = i_sum_en && (col < WIN_CNT);
    assign o_req  = sum_rd || i_cum_en;
    assign o_we   = i_done && !cum_rd;
    assign o_addr = o_we ? out_ptr : row_base + ADDR_W'(col);
    assign access = o_req && i_gnt;

    // the oldest slot is still zero while the first window fills.
    assign acc_upd = i_rvalid ? acc + WORD_W'(i_rdata.px.pix) - WORD_W'(win[WIN-1]) : acc;
    assign o_wdata.sum = acc_upd;

    assign o_counter    = col;
    assign o_start_gt_1 = start_cnt > 2'd1;
    assign o_row_eq_max = row == ROWS;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_cnt <= '0;
            col       <= '0;
            row       <= '0;
            row_base  <= '0;
            out_ptr   <= OUT_BASE;
            cum_rd    <= 1'b0;
        end else if (i_gnt) begin
            if (i_start_en) begin
                if (!start_cnt[1]) start_cnt <= start_cnt + 2'd1;
                row      <= '0;
                row_base <= '0;
                out_ptr  <= OUT_BASE;
            end else begin
                start_cnt <= '0;
            end
            if (i_ld_en) begin
                col    <= '0;
                cum_rd <= 1'b0;
            end
            if (access && i_count_en) begin
                if (o_we) begin
                    out_ptr <= out_ptr + 1'b1;
                    if (col == COLS) begin
                        // last sum of the row, step past the row end.
                        col      <= COLS + 10'd1;
                        row      <= row + 10'd1;
                        row_base <= row_base + ADDR_W'(`ROWSUM_COLS);
                    end else begin
                        cum_rd <= 1'b1;
                    end
                end else begin
                    col    <= col + 10'd1;
                    cum_rd <= 1'b0;
                end
            end
        end
    end

    // read data lands one cycle after its grant, so it is taken even during a stall.
    always_ff @(posedge clk) begin
        if (i_ld_en && i_gnt) begin
            acc <= '0;
            for (int i = 0; i < WIN; i++) win[i] <= '0;
        end else if (i_rvalid) begin
            acc    <= acc_upd;
            win[0] <= i_rdata.px.pix;
            for (int i = 1; i < WIN; i++) win[i] <= win[i-1];
        end
    end

endmodule

// ==== rowsum_assertions.sv ====
`include "rowsum_settings.svh"

module rowsum_assertions (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_gnt,
    input  logic [2:0] i_state,
    input  logic       i_sum_en,
    input  logic       i_cum_en,
    input  logic       i_progress_done
);

    int fail_cnt = 0;

    // the first window and the running sums never overlap.
    a_enables_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(i_sum_en && i_cum_en)
    ) else begin
        fail_cnt++;
        $error("sum and cum enables are high in the same cycle");
    end

    a_progress_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) i_progress_done |=> !i_progress_done
    ) else begin
        fail_cnt++;
        $error("progress done lasts longer than one cycle");
    end

    // a stalled filter keeps its state.
    a_state_held: assert property (
        @(posedge clk) disable iff (!rst_n) !i_gnt |=> $stable(i_state)
    ) else begin
        fail_cnt++;
        $error("controller state changed without a grant");
    end

endmodule

bind r2_controller rowsum_assertions u_assert (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_gnt           (i_gnt),
    .i_state         (state),
    .i_sum_en        (o_sum_en),
    .i_cum_en        (o_cum_en),
    .i_progress_done (o_progress_done)
);

// ==== rowsum_checker.sv ====
`include "rowsum_settings.svh"

module rowsum_checker
    import rowsum_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_pix_valid,
    input  logic [`ROWSUM_PIX_W-1:0]  i_pix_data,
    input  logic [`ROWSUM_ADDR_W-1:0] i_host_addr,
    input  logic                      i_pix_busy,
    input  logic                      i_progress_done,
    input  logic [`ROWSUM_WORD_W-1:0] i_host_rdata,
    input  logic                      i_host_rvalid,
    input  req_id_t                   i_gnt_id,
    input  logic                      i_flt_req,
    input  int                        i_first_sum,
    output int                        o_mismatch_cnt,
    output int                        o_protocol_cnt
);

    localparam int COLS     = `ROWSUM_COLS;
    localparam int ROWS     = `ROWSUM_ROWS;
    localparam int WIN      = `ROWSUM_WIN;
    localparam int WORD_W   = `ROWSUM_WORD_W;
    localparam int PIXELS   = ROWS * COLS;
    localparam int OUT_BASE = `ROWSUM_OUT_BASE;
    localparam int SUMS     = COLS - WIN + 1;
    localparam int DEPTH    = 1 << `ROWSUM_ADDR_W;

    logic [WORD_W-1:0] model [DEPTH];
    bit                known [DEPTH];
    int                pix_idx;
    bit                frame_pending;
    bit                rd_pending;
    int                rd_addr;
    int                mismatch_cnt = 0;
    int                protocol_cnt = 0;

    assign o_mismatch_cnt = mismatch_cnt;
    assign o_protocol_cnt = protocol_cnt;

    task automatic protocol_error(input string what);
        protocol_cnt++;
        $display("error at time %0t: %s", $time, what);
    endtask

    task automatic value_error(input string name, input int addr, input int exp, input int got);
        mismatch_cnt++;
        $display("mismatch at time %0t: %s at address %0d expected %0d got %0d",
                 $time, name, addr, exp, got);
    endtask

    task automatic forget_sums();
        for (int a = OUT_BASE; a < DEPTH; a++) known[a] = 1'b0;
    endtask

    // each sum covers pixels k through k+3 of its row.
    task automatic fill_sums();
        int sum;
        int slot;
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < SUMS; k++) begin
                sum = 0;
                for (int j = 0; j < WIN; j++) sum += int'(model[r * COLS + k + j]);
                slot = OUT_BASE + r * SUMS + k;
                model[slot] = WORD_W'(sum);
                known[slot] = 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            pix_idx       = 0;
            frame_pending = 1'b0;
            rd_pending    = 1'b0;
        end else begin
            if (i_pix_busy) protocol_error("pixel input busy although the loader has top priority");
            if (i_pix_valid) begin
                model[pix_idx] = WORD_W'(i_pix_data);
                known[pix_idx] = 1'b1;
                pix_idx++;
                if (pix_idx == PIXELS) begin
                    pix_idx = 0;
                    frame_pending = 1'b1;
                    forget_sums();
                end
            end
            if (i_progress_done) begin
                if (!frame_pending) protocol_error("progress done pulse without a loaded frame");
                else fill_sums();
                frame_pending = 1'b0;
            end
            if (rd_pending) begin
                if (!i_host_rvalid) begin
                    protocol_error("host read data not valid one cycle after the grant");
                end else begin
                    if (known[rd_addr] && i_host_rdata !== model[rd_addr])
                        value_error("o_host_rdata", rd_addr, int'(model[rd_addr]), int'(i_host_rdata));
                    if (rd_addr == OUT_BASE && i_first_sum >= 0 &&
                        int'(i_host_rdata) != i_first_sum)
                        value_error("o_host_rdata", rd_addr, i_first_sum, int'(i_host_rdata));
                end
            end else if (i_host_rvalid) begin
                protocol_error("host read data valid without a granted read");
            end
            if (i_gnt_id == REQ_HOST && i_flt_req)
                protocol_error("host granted while the filter requests the memory");
            rd_pending = (i_gnt_id == REQ_HOST);
            if (rd_pending) rd_addr = int'(i_host_addr);
        end
    end

endmodule

// ==== rowsum_pkg.sv ====
`include "rowsum_settings.svh"

package rowsum_pkg;

    // a frame memory word holds either one pixel or one window sum.
    typedef union packed {
        struct packed {
            logic [`ROWSUM_WORD_W-`ROWSUM_PIX_W-1:0] pad;
            logic [`ROWSUM_PIX_W-1:0]                pix;
        } px;
        logic [`ROWSUM_WORD_W-1:0] sum;
    } mem_word_t;

    // owner of the memory port in the current cycle.
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_LOADER,
        REQ_FILTER,
        REQ_HOST
    } req_id_t;

endpackage

// ==== rowsum_settings.svh ====
`ifndef ROWSUM_SETTINGS_SVH
`define ROWSUM_SETTINGS_SVH

// image geometry of one frame.
`define ROWSUM_COLS 7
`define ROWSUM_ROWS 4

`define ROWSUM_PIX_W 8
`define ROWSUM_WORD_W 16
`define ROWSUM_ADDR_W 6

// window sums are stored right after the last input pixel.
`define ROWSUM_OUT_BASE (`ROWSUM_ROWS * `ROWSUM_COLS)

// length of the horizontal window.
`define ROWSUM_WIN 4

`endif

// ==== rowsum_top.sv ====
`include "rowsum_settings.svh"

module rowsum_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_pix_valid,
    input  logic [`ROWSUM_PIX_W-1:0]  i_pix_data,
    input  logic                      i_host_req,
    input  logic [`ROWSUM_ADDR_W-1:0] i_host_addr,
    output logic                      o_pix_busy,
    output logic                      o_progress_done,
    output logic [`ROWSUM_WORD_W-1:0] o_host_rdata,
    output logic                      o_host_rvalid
);

    logic                      ld_req;
    logic                      ld_gnt;
    logic [`ROWSUM_ADDR_W-1:0] ld_addr;
    logic [`ROWSUM_WORD_W-1:0] ld_wdata;
    logic                      r1_done;

    logic                      flt_req;
    logic                      flt_gnt;
    logic                      flt_go;
    logic [`ROWSUM_ADDR_W-1:0] flt_addr;
    logic                      flt_we;
    logic [`ROWSUM_WORD_W-1:0] flt_wdata;
    logic [`ROWSUM_WORD_W-1:0] flt_rdata;
    logic                      flt_rvalid;

    logic       start_en;
    logic       ld_en;
    logic       count_en;
    logic       sum_en;
    logic       cum_en;
    logic       done_o;
    logic       start_gt_1;
    logic [9:0] counter;
    logic       row_eq_max;

    // the R2 pair steps when its access is granted or when it has none pending.
    assign flt_go = flt_gnt | ~flt_req;

    r1_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_pix_valid (i_pix_valid),
        .i_pix_data  (i_pix_data),
        .i_gnt       (ld_gnt),
        .o_req       (ld_req),
        .o_addr      (ld_addr),
        .o_wdata     (ld_wdata),
        .o_busy      (o_pix_busy),
        .o_done      (r1_done)
    );

    r2_controller u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_done          (r1_done),
        .i_gnt           (flt_go),
        .i_start_gt_1    (start_gt_1),
        .i_counter       (counter),
        .i_row_eq_max    (row_eq_max),
        .o_start_en      (start_en),
        .o_ld_en         (ld_en),
        .o_count_en      (count_en),
        .o_sum_en        (sum_en),
        .o_cum_en        (cum_en),
        .o_done          (done_o),
        .o_progress_done (o_progress_done)
    );

    r2_datapath u_dpath (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start_en   (start_en),
        .i_ld_en      (ld_en),
        .i_count_en   (count_en),
        .i_sum_en     (sum_en),
        .i_cum_en     (cum_en),
        .i_done       (done_o),
        .i_gnt        (flt_go),
        .o_start_gt_1 (start_gt_1),
        .o_counter    (counter),
        .o_row_eq_max (row_eq_max),
        .o_req        (flt_req),
        .o_addr       (flt_addr),
        .o_we         (flt_we),
        .o_wdata      (flt_wdata),
        .i_rdata      (flt_rdata),
        .i_rvalid     (flt_rvalid)
    );

    frame_mem_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_ld_req      (ld_req),
        .i_ld_addr     (ld_addr),
        .i_ld_wdata    (ld_wdata),
        .i_flt_req     (flt_req),
        .i_flt_addr    (flt_addr),
        .i_flt_we      (flt_we),
        .i_flt_wdata   (flt_wdata),
        .i_host_req    (i_host_req),
        .i_host_addr   (i_host_addr),
        .o_ld_gnt      (ld_gnt),
        .o_flt_gnt     (flt_gnt),
        .o_host_rdata  (o_host_rdata),
        .o_host_rvalid (o_host_rvalid),
        .o_flt_rdata   (flt_rdata),
        .o_flt_rvalid  (flt_rvalid)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rowsum -Mdir obj_dir \
    -f flist.f || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/Vtb_rowsum 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "PASS: all tests" && exit 0 || { echo "simulation failed"; exit 1; }

// ==== tb_rowsum.sv ====
`include "rowsum_settings.svh"

module tb_rowsum;

    localparam int CLK_HALF   = 50;
    localparam int DRV        = 10;
    localparam int COLS       = `ROWSUM_COLS;
    localparam int ROWS       = `ROWSUM_ROWS;
    localparam int PIXELS     = ROWS * COLS;
    localparam int SUMS       = ROWS * (COLS - `ROWSUM_WIN + 1);
    localparam int DEPTH      = 1 << `ROWSUM_ADDR_W;
    localparam int NUM_FRAMES = 6;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (PIXELS + SUMS) * 20;

    localparam int T_BASE  = 0;
    localparam int T_STEP  = 1;
    localparam int T_RND   = 2;
    localparam int T_HOST  = 3;
    localparam int T_FIRST = 4;

    // columns: first pixel, step per pixel, random pixels, host reads while
    // filtering, expected first sum of row 0 (-1 when the pixels are random).
    int frame_tab [NUM_FRAMES][5] = '{
        '{1,   1, 0, 0, 10},
        '{255, 0, 0, 0, 1020},
        '{0,   0, 1, 0, -1},
        '{200, 2, 0, 1, 812},
        '{0,   0, 0, 1, 0},
        '{0,   0, 1, 1, -1}
    };

    logic                      clk;
    logic                      rst_n;
    logic                      i_pix_valid;
    logic [`ROWSUM_PIX_W-1:0]  i_pix_data;
    logic                      i_host_req;
    logic [`ROWSUM_ADDR_W-1:0] i_host_addr;
    logic                      o_pix_busy;
    logic                      o_progress_done;
    logic [`ROWSUM_WORD_W-1:0] o_host_rdata;
    logic                      o_host_rvalid;
    int                        first_sum_exp;
    int                        done_cnt = 0;
    int                        mismatch_cnt;
    int                        protocol_cnt;
    int                        assert_cnt;

    rowsum_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_pix_valid     (i_pix_valid),
        .i_pix_data      (i_pix_data),
        .i_host_req      (i_host_req),
        .i_host_addr     (i_host_addr),
        .o_pix_busy      (o_pix_busy),
        .o_progress_done (o_progress_done),
        .o_host_rdata    (o_host_rdata),
        .o_host_rvalid   (o_host_rvalid)
    );

    rowsum_checker chk0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_pix_valid     (i_pix_valid),
        .i_pix_data      (i_pix_data),
        .i_host_addr     (i_host_addr),
        .i_pix_busy      (o_pix_busy),
        .i_progress_done (o_progress_done),
        .i_host_rdata    (o_host_rdata),
        .i_host_rvalid   (o_host_rvalid),
        .i_gnt_id        (dut0.u_arb.gnt_id),
        .i_flt_req       (dut0.flt_req),
        .i_first_sum     (first_sum_exp),
        .o_mismatch_cnt  (mismatch_cnt),
        .o_protocol_cnt  (protocol_cnt)
    );

    assign assert_cnt = dut0.u_ctrl.u_assert.fail_cnt;

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_n && o_progress_done) done_cnt++;
    end

    task automatic report_counts(input int timeouts);
        $display("errors: %0d mismatches, %0d protocol, %0d assertion, %0d timeout",
                 mismatch_cnt, protocol_cnt, assert_cnt, timeouts);
    endtask

    task automatic load_frame(input int f);
        int pix;
        for (int i = 0; i < PIXELS; i++) begin
            if (frame_tab[f][T_RND] != 0) pix = int'($urandom % 256);
            else pix = (frame_tab[f][T_BASE] + frame_tab[f][T_STEP] * i) % 256;
            @(posedge clk);
            #DRV;
            i_pix_valid = 1'b1;
            i_pix_data  = `ROWSUM_PIX_W'(pix);
        end
        @(posedge clk);
        #DRV;
        i_pix_valid = 1'b0;
    endtask

    // the request stays high until the read data comes back.
    task automatic host_read(input int addr);
        @(posedge clk);
        #DRV;
        i_host_req  = 1'b1;
        i_host_addr = `ROWSUM_ADDR_W'(addr);
        do begin
            @(posedge clk);
            #DRV;
        end while (!o_host_rvalid);
        i_host_req = 1'b0;
    endtask

    task automatic read_range(input int first, input int last);
        for (int a = first; a <= last; a++) host_read(a);
    endtask

    task automatic wait_frames(input int target);
        while (done_cnt < target) @(posedge clk);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        report_counts(1);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        i_pix_valid   = 1'b0;
        i_pix_data    = '0;
        i_host_req    = 1'b0;
        i_host_addr   = '0;
        first_sum_exp = -1;
        void'($urandom(67));
        repeat (2) @(posedge clk);
        #DRV;
        rst_n = 1'b1;
        // nothing is written yet, so these reads only exercise the read timing.
        read_range(0, 3);
        host_read(DEPTH - 1);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            first_sum_exp = -1;
            load_frame(f);
            if (frame_tab[f][T_HOST] != 0) read_range(0, PIXELS - 1);
            wait_frames(f + 1);
            first_sum_exp = frame_tab[f][T_FIRST];
            read_range(0, DEPTH - 1);
        end
        repeat (2) @(posedge clk);
        report_counts(0);
        if (mismatch_cnt + protocol_cnt + assert_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
